// File: src/cache_pkg.sv
package cache_pkg;

    // Cache geometry
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_BITS = 4;

    // LRU is a single bit per set, so this stays at two
    localparam int NUM_WAYS = 2;

    // --------------------
    // Shared types
    // --------------------
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W/8-1:0] strb_t;

    // Word 0 sits in the low bits
    typedef logic [WORD_W*WORDS_PER_LINE-1:0] line_t;

    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

endpackage

// File: src/cache_way.sv
module cache_way #(
    parameter int INDEX_BITS = 4,
    localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_BITS - INDEX_BITS,
    localparam int SEL_W = $clog2(cache_pkg::WORDS_PER_LINE)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [INDEX_BITS-1:0] rd_index,
    output logic [TAG_W-1:0]      rd_tag,
    output logic                  rd_valid,
    output logic                  rd_dirty,
    output cache_pkg::line_t      rd_line,
    input  logic                  fill_en,
    input  logic [INDEX_BITS-1:0] fill_index,
    input  logic [TAG_W-1:0]      fill_tag,
    input  cache_pkg::line_t      fill_line,
    input  logic                  word_en,
    input  logic [INDEX_BITS-1:0] word_index,
    input  logic [SEL_W-1:0]      word_sel,
    input  cache_pkg::strb_t      word_strb,
    input  cache_pkg::word_t      word_data
);
    import cache_pkg::*;

    localparam int SETS = 1 << INDEX_BITS;

    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;
    logic [TAG_W-1:0] tag_mem [SETS];
    line_t line_mem [SETS];

    // Word write after fill, so a same-cycle merge lands on the new line
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_en) begin
                valid_q[fill_index] <= 1'b1;
                dirty_q[fill_index] <= 1'b0;
            end
            if (word_en) begin
                dirty_q[word_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_index] <= fill_tag;
            line_mem[fill_index] <= fill_line;
        end
        if (word_en) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (word_strb[b]) begin
                    line_mem[word_index][word_sel*WORD_W + b*8 +: 8] <= word_data[b*8 +: 8];
                end
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        rd_tag <= tag_mem[rd_index];
        rd_line <= line_mem[rd_index];
        rd_valid <= valid_q[rd_index];
        rd_dirty <= dirty_q[rd_index];
    end

endmodule

// File: src/hit_select.sv
module hit_select #(
    parameter int INDEX_BITS = 4,
    localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_BITS - INDEX_BITS,
    localparam int SEL_W = $clog2(cache_pkg::WORDS_PER_LINE)
) (
    input  logic [TAG_W-1:0]                                req_tag,
    input  logic [SEL_W-1:0]                                word_sel,
    input  logic                                            lru_bit,
    input  logic [cache_pkg::NUM_WAYS-1:0][TAG_W-1:0]       way_tags,
    input  logic [cache_pkg::NUM_WAYS-1:0]                  way_valids,
    input  logic [cache_pkg::NUM_WAYS-1:0]                  way_dirtys,
    input  cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0]      way_lines,
    output logic                                            hit,
    output cache_pkg::way_t                                 hit_way,
    output cache_pkg::word_t                                hit_word,
    output cache_pkg::way_t                                 victim_way,
    output logic [TAG_W-1:0]                                victim_tag,
    output logic                                            victim_dirty,
    output cache_pkg::line_t                                victim_line
);
    import cache_pkg::*;

    line_t hit_line;

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_valids[w] && way_tags[w] == req_tag) begin
                hit = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_line = way_lines[hit_way];
    assign hit_word = hit_line[word_sel*WORD_W +: WORD_W];

    // Lowest invalid way wins, else the LRU way
    always_comb begin
        victim_way = way_t'(lru_bit);
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!way_valids[w]) begin
                victim_way = way_t'(w);
            end
        end
    end

    assign victim_tag = way_tags[victim_way];
    assign victim_dirty = way_dirtys[victim_way] && way_valids[victim_way];
    assign victim_line = way_lines[victim_way];

endmodule

// File: src/refill_unit.sv
module refill_unit #(
    parameter int INDEX_BITS = 4,
    localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_BITS - INDEX_BITS
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              refill_start,
    input  cache_pkg::addr_t  refill_addr,
    input  cache_pkg::addr_t  victim_addr,
    input  logic              writeback,
    input  cache_pkg::line_t  victim_data,
    output logic              fill_valid,
    output cache_pkg::line_t  fill_line,
    output logic              busy,
    output logic              mem_rd_req_valid,
    output cache_pkg::addr_t  mem_rd_addr,
    input  logic              mem_rd_req_ready,
    input  logic              mem_rd_data_valid,
    input  cache_pkg::word_t  mem_rd_data,
    input  logic              mem_rd_last,
    output logic              mem_rd_data_ready,
    output logic              mem_wr_req_valid,
    output cache_pkg::addr_t  mem_wr_addr,
    input  logic              mem_wr_req_ready,
    output logic              mem_wr_data_valid,
    output cache_pkg::word_t  mem_wr_data,
    output logic              mem_wr_last,
    input  logic              mem_wr_data_ready
);
    import cache_pkg::*;

    localparam int BEAT_W = $clog2(WORDS_PER_LINE);
    localparam int S_WAIT = 0, S_RREQ = 1, S_RDAT = 2, S_FILL = 3, S_WREQ = 4, S_WDAT = 5;

    logic [5:0] state;
    logic [5:0] state_next;
    logic [BEAT_W-1:0] beat_q;
    logic [INDEX_BITS-1:0] index_q;
    logic [TAG_W-1:0] rtag_q;
    logic [TAG_W-1:0] vtag_q;
    logic wb_q;
    line_t victim_q;
    line_t line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= 6'b1 << S_WAIT;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (1'b1)
            state[S_WAIT]: if (refill_start) state_next = 6'b1 << S_RREQ;
            state[S_RREQ]: if (mem_rd_req_ready) state_next = 6'b1 << S_RDAT;
            state[S_RDAT]: if (mem_rd_data_valid && mem_rd_last) state_next = 6'b1 << S_FILL;
            state[S_FILL]: state_next = wb_q ? 6'b1 << S_WREQ : 6'b1 << S_WAIT;
            state[S_WREQ]: if (mem_wr_req_ready) state_next = 6'b1 << S_WDAT;
            state[S_WDAT]: if (mem_wr_data_ready && mem_wr_last) state_next = 6'b1 << S_WAIT;
            default: state_next = 6'b1 << S_WAIT;
        endcase
    end

    // Victim shares the set index with the missing line
    always_ff @(posedge clk) begin
        if (state[S_WAIT] && refill_start) begin
            index_q <= refill_addr[OFFSET_BITS +: INDEX_BITS];
            rtag_q <= refill_addr[ADDR_W-1 -: TAG_W];
            vtag_q <= victim_addr[ADDR_W-1 -: TAG_W];
            wb_q <= writeback;
            victim_q <= victim_data;
        end
        if (mem_rd_data_valid && mem_rd_data_ready) begin
            line_q[beat_q*WORD_W +: WORD_W] <= mem_rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state[S_RREQ] || state[S_WREQ]) begin
            beat_q <= '0;
        end else if ((mem_rd_data_valid && mem_rd_data_ready) ||
                     (mem_wr_data_valid && mem_wr_data_ready)) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    // --------------------
    // Memory side
    // --------------------
    assign mem_rd_req_valid = state[S_RREQ];
    assign mem_rd_addr = {rtag_q, index_q, OFFSET_BITS'(0)};
    assign mem_rd_data_ready = state[S_RDAT];
    assign mem_wr_req_valid = state[S_WREQ];
    assign mem_wr_addr = {vtag_q, index_q, OFFSET_BITS'(0)};
    assign mem_wr_data_valid = state[S_WDAT];
    assign mem_wr_data = victim_q[beat_q*WORD_W +: WORD_W];
    assign mem_wr_last = state[S_WDAT] && beat_q == BEAT_W'(WORDS_PER_LINE - 1);

    assign fill_valid = state[S_FILL];
    assign fill_line = line_q;
    assign busy = ~state[S_WAIT];

endmodule

// File: src/cache_ctrl.sv
module cache_ctrl #(
    parameter int INDEX_BITS = 4,
    localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_BITS - INDEX_BITS,
    localparam int SEL_W = $clog2(cache_pkg::WORDS_PER_LINE)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  cache_pkg::addr_t               req_addr,
    input  logic                           req_write,
    input  cache_pkg::word_t               req_wdata,
    input  cache_pkg::strb_t               req_strb,
    output logic                           resp_valid,
    input  logic                           resp_ready,
    output cache_pkg::word_t               resp_data,
    output logic [INDEX_BITS-1:0]          lookup_index,
    output logic [cache_pkg::NUM_WAYS-1:0] fill_way_en,
    output logic [cache_pkg::NUM_WAYS-1:0] word_way_en,
    output logic [TAG_W-1:0]               fill_tag,
    output logic [SEL_W-1:0]               word_sel,
    output cache_pkg::strb_t               word_strb,
    output cache_pkg::word_t               word_data,
    input  logic                           hit,
    input  cache_pkg::way_t                hit_way,
    input  cache_pkg::word_t               hit_word,
    input  cache_pkg::way_t                victim_way,
    input  logic [TAG_W-1:0]               victim_tag,
    input  logic                           victim_dirty,
    input  cache_pkg::line_t               victim_line,
    output logic                           lru_bit,
    output logic                           refill_start,
    output cache_pkg::addr_t               refill_addr,
    output cache_pkg::addr_t               victim_addr,
    output logic                           writeback,
    output cache_pkg::line_t               victim_data,
    input  logic                           fill_valid,
    input  cache_pkg::line_t               fill_line,
    input  logic                           refill_busy
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_COMPARE,
        S_WAIT_REFILL,
        S_RESPOND,
        S_DRAIN
    } state_t;

    state_t state;
    state_t state_next;
    addr_t addr_q;
    logic write_q;
    word_t wdata_q;
    strb_t strb_q;
    way_t fill_way_q;
    logic [(1 << INDEX_BITS)-1:0] lru_q;
    logic compare_hit;
    logic fill_done;

    // Request fields, held for the whole transaction
    assign lookup_index = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign fill_tag = addr_q[ADDR_W-1 -: TAG_W];
    assign word_sel = addr_q[OFFSET_BITS-SEL_W +: SEL_W];
    assign word_strb = strb_q;
    assign word_data = wdata_q;

    assign req_ready = state == S_IDLE;
    assign resp_valid = state == S_RESPOND;
    assign lru_bit = lru_q[lookup_index];

    assign compare_hit = state == S_COMPARE && hit;
    assign fill_done = state == S_WAIT_REFILL && fill_valid;

    // --------------------
    // Refill request
    // --------------------
    assign refill_start = state == S_COMPARE && !hit;
    assign refill_addr = {addr_q[ADDR_W-1:OFFSET_BITS], OFFSET_BITS'(0)};
    assign victim_addr = {victim_tag, lookup_index, OFFSET_BITS'(0)};
    assign writeback = victim_dirty;
    assign victim_data = victim_line;

    always_comb begin
        fill_way_en = '0;
        word_way_en = '0;
        if (compare_hit && write_q) begin
            word_way_en[hit_way] = 1'b1;
        end
        // Install and merge in the same cycle
        if (fill_done) begin
            fill_way_en[fill_way_q] = 1'b1;
            word_way_en[fill_way_q] = write_q;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: if (req_valid) state_next = S_LOOKUP;
            S_LOOKUP: state_next = S_COMPARE;
            S_COMPARE: state_next = hit ? S_RESPOND : S_WAIT_REFILL;
            S_WAIT_REFILL: if (fill_valid) state_next = S_RESPOND;
            S_RESPOND: if (resp_ready) state_next = refill_busy ? S_DRAIN : S_IDLE;
            S_DRAIN: if (!refill_busy) state_next = S_IDLE;
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            lru_q <= '0;
        end else begin
            state <= state_next;
            // LRU points at the way not just used
            if (compare_hit) begin
                lru_q[lookup_index] <= ~hit_way;
            end else if (fill_done) begin
                lru_q[lookup_index] <= ~fill_way_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            addr_q <= req_addr;
            write_q <= req_write;
            wdata_q <= req_wdata;
            strb_q <= req_strb;
        end
        if (refill_start) begin
            fill_way_q <= victim_way;
        end
        if (compare_hit) begin
            resp_data <= hit_word;
        end else if (fill_done) begin
            resp_data <= fill_line[word_sel*WORD_W +: WORD_W];
        end
    end

endmodule

// File: src/cache_top.sv
module cache_top #(
    parameter int INDEX_BITS = 4,
    localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_BITS - INDEX_BITS,
    localparam int SEL_W = $clog2(cache_pkg::WORDS_PER_LINE)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    output logic             req_ready,
    input  cache_pkg::addr_t req_addr,
    input  logic             req_write,
    input  cache_pkg::word_t req_wdata,
    input  cache_pkg::strb_t req_strb,
    output logic             resp_valid,
    input  logic             resp_ready,
    output cache_pkg::word_t resp_data,
    output logic             mem_rd_req_valid,
    output cache_pkg::addr_t mem_rd_addr,
    input  logic             mem_rd_req_ready,
    input  logic             mem_rd_data_valid,
    input  cache_pkg::word_t mem_rd_data,
    input  logic             mem_rd_last,
    output logic             mem_rd_data_ready,
    output logic             mem_wr_req_valid,
    output cache_pkg::addr_t mem_wr_addr,
    input  logic             mem_wr_req_ready,
    output logic             mem_wr_data_valid,
    output cache_pkg::word_t mem_wr_data,
    output logic             mem_wr_last,
    input  logic             mem_wr_data_ready
);
    import cache_pkg::*;

    logic [INDEX_BITS-1:0] lookup_index;
    logic [NUM_WAYS-1:0] fill_way_en;
    logic [NUM_WAYS-1:0] word_way_en;
    logic [TAG_W-1:0] fill_tag;
    logic [SEL_W-1:0] word_sel;
    strb_t word_strb;
    word_t word_data;

    // Way read ports
    logic [NUM_WAYS-1:0][TAG_W-1:0] way_tags;
    logic [NUM_WAYS-1:0] way_valids;
    logic [NUM_WAYS-1:0] way_dirtys;
    line_t [NUM_WAYS-1:0] way_lines;

    logic hit;
    way_t hit_way;
    word_t hit_word;
    way_t victim_way;
    logic [TAG_W-1:0] victim_tag;
    logic victim_dirty;
    line_t victim_line;
    logic lru_bit;

    logic refill_start;
    addr_t refill_addr;
    addr_t victim_addr;
    logic writeback;
    line_t victim_data;
    logic fill_valid;
    line_t fill_line;
    logic refill_busy;

    cache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (.*);

    for (genvar w = 0; w < NUM_WAYS; w++) begin : ways
        cache_way #(.INDEX_BITS(INDEX_BITS)) u_way (
            .clk(clk),
            .rst(rst),
            .rd_index(lookup_index),
            .rd_tag(way_tags[w]),
            .rd_valid(way_valids[w]),
            .rd_dirty(way_dirtys[w]),
            .rd_line(way_lines[w]),
            .fill_en(fill_way_en[w]),
            .fill_index(lookup_index),
            .fill_tag(fill_tag),
            .fill_line(fill_line),
            .word_en(word_way_en[w]),
            .word_index(lookup_index),
            .word_sel(word_sel),
            .word_strb(word_strb),
            .word_data(word_data)
        );
    end

    hit_select #(.INDEX_BITS(INDEX_BITS)) u_hit_select (
        .*,
        .req_tag(fill_tag)
    );

    refill_unit #(.INDEX_BITS(INDEX_BITS)) u_refill (
        .*,
        .busy(refill_busy)
    );

endmodule

// File: dv/cache_asserts.sv
module cache_asserts (
    input logic             clk,
    input logic             rst,
    input logic             req_ready,
    input logic             resp_valid,
    input logic             resp_ready,
    input cache_pkg::word_t resp_data,
    input logic             mem_rd_req_valid,
    input logic             mem_rd_req_ready,
    input logic             mem_wr_req_valid,
    input logic             mem_wr_req_ready,
    input logic             mem_wr_data_valid,
    input logic             mem_wr_data_ready,
    input logic             mem_wr_last
);

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
        else $error("Response dropped or changed while resp_ready was low");

    // --------------------
    // Memory channels
    // --------------------
    rd_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req_valid && !mem_rd_req_ready |=> mem_rd_req_valid)
        else $error("mem_rd_req_valid dropped before its ready");

    wr_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req_valid && !mem_wr_req_ready |=> mem_wr_req_valid)
        else $error("mem_wr_req_valid dropped before its ready");

    wr_data_hold: assert property (@(posedge clk) disable iff (rst)
        mem_wr_data_valid && !mem_wr_data_ready |=> mem_wr_data_valid)
        else $error("mem_wr_data_valid dropped before its ready");

    // Burst ends on the beat marked last
    wr_last_end: assert property (@(posedge clk) disable iff (rst)
        mem_wr_last && mem_wr_data_valid && mem_wr_data_ready
            |=> !mem_wr_data_valid && !mem_wr_last)
        else $error("Write burst continued after the beat marked mem_wr_last");

    // One request in flight, write-back included
    busy_ready: assert property (@(posedge clk) disable iff (rst)
        resp_valid || mem_rd_req_valid || mem_wr_req_valid || mem_wr_data_valid
            |-> !req_ready)
        else $error("req_ready high while a request or write-back is in flight");

endmodule

bind cache_top cache_asserts u_asserts (.*);

// File: dv/tb_cache.sv
module tb_cache;
    import cache_pkg::*;

    localparam int PAT_MAX = 64;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic req_valid = 1'b0;
    logic req_ready;
    addr_t req_addr = '0;
    logic req_write = 1'b0;
    word_t req_wdata = '0;
    strb_t req_strb = '0;
    logic resp_valid;
    logic resp_ready = 1'b0;
    word_t resp_data;
    logic mem_rd_req_valid;
    addr_t mem_rd_addr;
    logic mem_rd_req_ready = 1'b0;
    logic mem_rd_data_valid = 1'b0;
    word_t mem_rd_data = '0;
    logic mem_rd_last = 1'b0;
    logic mem_rd_data_ready;
    logic mem_wr_req_valid;
    addr_t mem_wr_addr;
    logic mem_wr_req_ready = 1'b0;
    logic mem_wr_data_valid;
    word_t mem_wr_data;
    logic mem_wr_last;
    logic mem_wr_data_ready = 1'b0;

    logic [31:0] pat [PAT_MAX*4];
    word_t mem_q [addr_t];
    word_t ref_mem [addr_t];
    int rd_reqs [addr_t];
    int seed = 45;
    int errors = 0;
    int n_pat = 0;
    int cycles = 0;
    int limit = 100;
    addr_t prev_line = 32'hffff_ffff;
    addr_t rd_base;
    addr_t wr_base;
    addr_t waddr;
    int rd_beat;
    int wr_beat;
    logic rd_pending;
    logic wr_pending;

    cache_top #(.INDEX_BITS(4)) UUT (.*);

    always #4 clk = ~clk;

    function automatic word_t init_word(addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5A5A0000;
    endfunction

    function automatic word_t model_word(addr_t a);
        return mem_q.exists(a) ? mem_q[a] : init_word(a);
    endfunction

    function automatic word_t ref_word(addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
    endfunction

    function automatic int read_count(addr_t line);
        return rd_reqs.exists(line) ? rd_reqs[line] : 0;
    endfunction

    function automatic word_t merge_word(word_t old, word_t data, strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // --------------------
    // Burst memory model
    // --------------------
    always @(posedge clk) begin
        if (rst) begin
            rd_pending = 1'b0;
            wr_pending = 1'b0;
            mem_rd_req_ready <= 1'b0;
            mem_rd_data_valid <= 1'b0;
            mem_wr_req_ready <= 1'b0;
            mem_wr_data_ready <= 1'b0;
            resp_ready <= 1'b0;
        end else begin
            if (mem_rd_data_valid && mem_rd_data_ready) begin
                rd_beat++;
                if (rd_beat == WORDS_PER_LINE) rd_pending = 1'b0;
            end
            if (mem_rd_req_valid && mem_rd_req_ready) begin
                assert (mem_rd_addr == {req_addr[31:4], 4'h0}) else begin
                    errors++;
                    $display("Fail mem_rd_addr: got %h, expected %h",
                             mem_rd_addr, {req_addr[31:4], 4'h0});
                end
                rd_base = mem_rd_addr;
                rd_beat = 0;
                rd_pending = 1'b1;
                rd_reqs[mem_rd_addr] = read_count(mem_rd_addr) + 1;
            end
            // A presented beat stays until taken
            if (!mem_rd_data_valid || mem_rd_data_ready) begin
                mem_rd_data_valid <= rd_pending && (($random(seed) & 3) != 0);
                mem_rd_data <= model_word(rd_base + addr_t'(rd_beat * 4));
                mem_rd_last <= rd_beat == WORDS_PER_LINE - 1;
            end

            if (mem_wr_req_valid && mem_wr_req_ready) begin
                assert (mem_wr_addr[3:0] == 4'h0) else begin
                    errors++;
                    $display("Fail mem_wr_addr: got %h, expected %h",
                             mem_wr_addr, {mem_wr_addr[31:4], 4'h0});
                end
                wr_base = mem_wr_addr;
                wr_beat = 0;
                wr_pending = 1'b1;
            end
            if (mem_wr_data_valid && mem_wr_data_ready) begin
                waddr = wr_base + addr_t'(wr_beat * 4);
                assert (wr_pending) else begin
                    errors++;
                    $display("Write-back beat arrived without a write request");
                end
                assert (mem_wr_data == ref_word(waddr)) else begin
                    errors++;
                    $display("Fail mem_wr_data at %h: got %h, expected %h",
                             waddr, mem_wr_data, ref_word(waddr));
                end
                assert (mem_wr_last == (wr_beat == WORDS_PER_LINE - 1)) else begin
                    errors++;
                    $display("Fail mem_wr_last at %h: got %h, expected %h",
                             waddr, mem_wr_last, wr_beat == WORDS_PER_LINE - 1);
                end
                mem_q[waddr] = mem_wr_data;
                wr_beat++;
                if (wr_beat == WORDS_PER_LINE) wr_pending = 1'b0;
            end

            mem_rd_req_ready <= ($random(seed) & 1) != 0;
            mem_wr_req_ready <= ($random(seed) & 1) != 0;
            mem_wr_data_ready <= ($random(seed) & 3) != 0;
            resp_ready <= ($random(seed) & 1) != 0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Errors: %0d", errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------
    // Requester
    // --------------------
    task automatic run_request(input int i);
        addr_t addr;
        addr_t line;
        logic write;
        word_t wdata;
        strb_t strb;
        word_t expected;
        int reads_before;
        addr = pat[i*4+1];
        write = pat[i*4][0];
        wdata = pat[i*4+2];
        strb = pat[i*4+3][3:0];
        line = {addr[31:4], 4'h0};
        reads_before = read_count(line);
        req_valid <= 1'b1;
        req_addr <= addr;
        req_write <= write;
        req_wdata <= wdata;
        req_strb <= strb;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
        expected = ref_word(addr);
        if (write) ref_mem[addr] = merge_word(expected, wdata, strb);
        do @(posedge clk); while (!(resp_valid && resp_ready));
        if (!write) begin
            assert (resp_data == expected) else begin
                errors++;
                $display("Fail resp_data at %h: got %h, expected %h", addr, resp_data, expected);
            end
        end
        // Same line as the request before, so it must hit
        assert (line != prev_line || read_count(line) == reads_before) else begin
            errors++;
            $display("Fail mem_rd_req count for %h: got %h, expected %h",
                     line, read_count(line), reads_before);
        end
        prev_line = line;
    endtask

    task automatic finish_run();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        for (int i = 0; i < PAT_MAX * 4; i++) begin
            pat[i] = 32'hff;
        end
        $readmemh("dv/cache_patterns.txt", pat);
        while (n_pat < PAT_MAX && pat[n_pat*4] != 32'hff) begin
            n_pat++;
        end
        limit = n_pat * 80 + 100;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        assert (n_pat > 0) else begin
            errors++;
            $display("No requests were loaded from the pattern file");
        end
        for (int i = 0; i < n_pat; i++) begin
            run_request(i);
        end
        finish_run();
    end

endmodule

// File: dv/cache_patterns.txt
// op (0 read, 1 write, ff ends the list), byte address, write data, strobe
// Fresh reads
0 00000100 00000000 0
0 0000010c 00000000 0
// Write miss, read back, partial write hit
1 00000208 11223344 f
0 00000208 00000000 0
1 00000208 aabbccdd 5
0 00000208 00000000 0
0 0000020c 00000000 0
// Three lines in set 3, dirty evictions
1 00001030 01010101 f
1 00002034 02020202 3
1 00003038 03030303 c
0 00001030 00000000 0
0 00002034 00000000 0
0 00003038 00000000 0
1 0000103c 04040404 f
0 00002034 00000000 0
0 00001030 00000000 0
// Resident line, no new refill
0 00001034 00000000 0
0 00001038 00000000 0
0 0000103c 00000000 0
0 00001030 00000000 0
ff 00000000 00000000 0

// File: sim.f
src/cache_pkg.sv
src/cache_way.sv
src/hit_select.sv
src/refill_unit.sv
src/cache_ctrl.sv
src/cache_top.sv
dv/cache_asserts.sv
dv/tb_cache.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cache -f sim.f -o sim_cache
./obj_dir/sim_cache | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
